// ==== logic/tanimoto_pkg.sv ====
package tanimoto_pkg;

    // Fingerprint and count widths
    localparam int VEC_WIDTH = 32;
    localparam int CNT_WIDTH = 6;
    localparam int SUM_WIDTH = 7;

    // One lane per reference vector
    localparam int NUM_REFS = 4;
    localparam int REF_SEL_WIDTH = $clog2(NUM_REFS);
    localparam int ID_WIDTH = 8;

    // One threshold entry per possible value of c
    localparam int TABLE_DEPTH = VEC_WIDTH + 1;

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);
    // Leaf entries held back for pairs still inside a lane
    localparam int FIFO_SLACK = 3;

    typedef struct packed {
        logic [ID_WIDTH-1:0] ref_id;
        logic [ID_WIDTH-1:0] cmp_id;
    } id_pair_t;

    // Vector weight
    function automatic logic [CNT_WIDTH-1:0] popcount(input logic [VEC_WIDTH-1:0] vec);
        logic [CNT_WIDTH-1:0] cnt;
        cnt = '0;
        for (int i = 0; i < VEC_WIDTH; i++) begin
            cnt = cnt + CNT_WIDTH'(vec[i]);
        end
        return cnt;
    endfunction

endpackage

// ==== logic/vector_loader.sv ====
`timescale 1ns/1ps

module vector_loader (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [tanimoto_pkg::VEC_WIDTH-1:0]   i_vec_data,
    input  logic                                 i_vec_valid,
    input  logic                                 i_room,
    output logic                                 o_vec_ready,
    output logic [tanimoto_pkg::VEC_WIDTH-1:0]   o_ref_vec [tanimoto_pkg::NUM_REFS],
    output logic [tanimoto_pkg::CNT_WIDTH-1:0]   o_ref_cnt [tanimoto_pkg::NUM_REFS],
    output logic [tanimoto_pkg::VEC_WIDTH-1:0]   o_cmp_vec,
    output logic [tanimoto_pkg::CNT_WIDTH-1:0]   o_cmp_cnt,
    output logic [tanimoto_pkg::ID_WIDTH-1:0]    o_cmp_id,
    output logic                                 o_cmp_valid
);

    logic                                load_mode;
    logic                                ready_en;
    logic                                accept;
    logic [tanimoto_pkg::ID_WIDTH-1:0]   next_id;
    logic [tanimoto_pkg::CNT_WIDTH-1:0]  vec_cnt;

    // References are always taken and compare vectors only while the leaves have room
    assign o_vec_ready = ready_en && (load_mode || i_room);
    assign accept = i_vec_valid && o_vec_ready;
    assign vec_cnt = tanimoto_pkg::popcount(i_vec_data);

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_en <= 1'b0;
            load_mode <= 1'b1;
            next_id <= '0;
            o_cmp_valid <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            o_cmp_valid <= accept && !load_mode;
            if (accept) begin
                next_id <= next_id + 1'b1;
                // Last reference slot filled
                if (load_mode && next_id == tanimoto_pkg::ID_WIDTH'(tanimoto_pkg::NUM_REFS - 1)) begin
                    load_mode <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && load_mode) begin
            o_ref_vec[next_id[tanimoto_pkg::REF_SEL_WIDTH-1:0]] <= i_vec_data;
            o_ref_cnt[next_id[tanimoto_pkg::REF_SEL_WIDTH-1:0]] <= vec_cnt;
        end
        if (accept && !load_mode) begin
            o_cmp_vec <= i_vec_data;
            o_cmp_cnt <= vec_cnt;
            o_cmp_id <= next_id;
        end
    end

    // Valid and data hold until the vector is taken
    a_valid_hold: assert property (@(posedge clk) disable iff (rst)
        i_vec_valid && !o_vec_ready |=> i_vec_valid && $stable(i_vec_data));

endmodule

// ==== logic/threshold_table.sv ====
`timescale 1ns/1ps

module threshold_table (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 i_wb_cyc,
    input  logic                                 i_wb_stb,
    input  logic                                 i_wb_we,
    input  logic [tanimoto_pkg::CNT_WIDTH-1:0]   i_wb_adr,
    input  logic [tanimoto_pkg::SUM_WIDTH-1:0]   i_wb_dat,
    input  logic [tanimoto_pkg::CNT_WIDTH-1:0]   i_lookup_idx [tanimoto_pkg::NUM_REFS],
    output logic                                 o_wb_ack,
    output logic [tanimoto_pkg::SUM_WIDTH-1:0]   o_wb_dat,
    output logic [tanimoto_pkg::SUM_WIDTH-1:0]   o_lookup_val [tanimoto_pkg::NUM_REFS]
);

    logic [tanimoto_pkg::SUM_WIDTH-1:0] table_mem [tanimoto_pkg::TABLE_DEPTH];
    logic                               wb_req;
    logic                               adr_ok;

    // New request only while no ack is out, so each cycle gets one ack
    assign wb_req = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign adr_ok = i_wb_adr < tanimoto_pkg::CNT_WIDTH'(tanimoto_pkg::TABLE_DEPTH);

    // Entries clear to zero, which blocks every pair
    always_ff @(posedge clk) begin
        if (rst) begin
            o_wb_ack <= 1'b0;
            for (int i = 0; i < tanimoto_pkg::TABLE_DEPTH; i++) begin
                table_mem[i] <= '0;
            end
        end else begin
            o_wb_ack <= wb_req;
            if (wb_req && i_wb_we && adr_ok) begin
                table_mem[i_wb_adr] <= i_wb_dat;
            end
        end
    end

    // Out of range addresses read back as zero
    always_ff @(posedge clk) begin
        if (wb_req) begin
            o_wb_dat <= adr_ok ? table_mem[i_wb_adr] : '0;
        end
    end

    // One registered read port per lane
    always_ff @(posedge clk) begin
        for (int l = 0; l < tanimoto_pkg::NUM_REFS; l++) begin
            o_lookup_val[l] <= table_mem[i_lookup_idx[l]];
        end
    end

    // Master keeps the strobe up until it sees the ack
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        o_wb_ack |-> (i_wb_cyc && i_wb_stb));

endmodule

// ==== logic/similarity_lane.sv ====
`timescale 1ns/1ps

module similarity_lane #(
    parameter int LANE_ID = 0
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [tanimoto_pkg::VEC_WIDTH-1:0]   i_ref_vec,
    input  logic [tanimoto_pkg::CNT_WIDTH-1:0]   i_ref_cnt,
    input  logic [tanimoto_pkg::VEC_WIDTH-1:0]   i_cmp_vec,
    input  logic [tanimoto_pkg::CNT_WIDTH-1:0]   i_cmp_cnt,
    input  logic [tanimoto_pkg::ID_WIDTH-1:0]    i_cmp_id,
    input  logic                                 i_cmp_valid,
    input  logic [tanimoto_pkg::SUM_WIDTH-1:0]   i_lookup_val,
    output logic [tanimoto_pkg::CNT_WIDTH-1:0]   o_lookup_idx,
    output logic                                 o_pair_wr,
    output tanimoto_pkg::id_pair_t               o_pair_data
);

    logic [tanimoto_pkg::CNT_WIDTH-1:0]  s1_common;
    logic [tanimoto_pkg::SUM_WIDTH-1:0]  s1_sum;
    logic [tanimoto_pkg::ID_WIDTH-1:0]   s1_id;
    logic                                s1_valid;
    logic [tanimoto_pkg::SUM_WIDTH-1:0]  s2_sum;
    logic [tanimoto_pkg::ID_WIDTH-1:0]   s2_id;
    logic                                s2_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= i_cmp_valid;
            s2_valid <= s1_valid;
        end
    end

    // Stage 1 registers c and a+b
    always_ff @(posedge clk) begin
        s1_common <= tanimoto_pkg::popcount(i_ref_vec & i_cmp_vec);
        s1_sum <= tanimoto_pkg::SUM_WIDTH'(i_ref_cnt) + tanimoto_pkg::SUM_WIDTH'(i_cmp_cnt);
        s1_id <= i_cmp_id;
    end

    // c addresses the table and the entry returns with stage 2
    assign o_lookup_idx = s1_common;

    // Hold sum and ID while the table read is in progress
    always_ff @(posedge clk) begin
        s2_sum <= s1_sum;
        s2_id <= s1_id;
    end

    // Stage 2 tests a+b against the largest allowed sum for this c
    assign o_pair_wr = s2_valid && (s2_sum <= i_lookup_val);
    assign o_pair_data.ref_id = tanimoto_pkg::ID_WIDTH'(LANE_ID);
    assign o_pair_data.cmp_id = s2_id;

endmodule

// ==== logic/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      i_wr,
    input  tanimoto_pkg::id_pair_t                    i_wr_data,
    input  logic                                      i_rd,
    output tanimoto_pkg::id_pair_t                    o_rd_data,
    output logic                                      o_empty,
    output logic                                      o_full,
    output logic [tanimoto_pkg::FIFO_CNT_WIDTH-1:0]   o_count
);

    tanimoto_pkg::id_pair_t                    mem [tanimoto_pkg::FIFO_DEPTH];
    logic [tanimoto_pkg::FIFO_PTR_WIDTH-1:0]   wr_ptr;
    logic [tanimoto_pkg::FIFO_PTR_WIDTH-1:0]   rd_ptr;
    logic                                      do_wr;
    logic                                      do_rd;

    assign o_empty = (o_count == '0);
    assign o_full = (o_count == tanimoto_pkg::FIFO_CNT_WIDTH'(tanimoto_pkg::FIFO_DEPTH));
    assign do_wr = i_wr && !o_full;
    assign do_rd = i_rd && !o_empty;

    // Head entry is visible without a read
    assign o_rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            o_count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            o_count <= o_count + tanimoto_pkg::FIFO_CNT_WIDTH'(do_wr)
                       - tanimoto_pkg::FIFO_CNT_WIDTH'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // Leaf slack and the merge rule keep writers off a full FIFO
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        i_wr |-> !o_full);

    // Readers only pop a visible head entry
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        i_rd |-> !o_empty);

endmodule

// ==== logic/id_fifo_tree.sv ====
`timescale 1ns/1ps

module id_fifo_tree (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [tanimoto_pkg::NUM_REFS-1:0]       i_leaf_wr,
    input  tanimoto_pkg::id_pair_t                  i_leaf_data [tanimoto_pkg::NUM_REFS],
    input  logic                                    i_root_read,
    output logic                                    o_room,
    output logic                                    o_root_valid,
    output tanimoto_pkg::id_pair_t                  o_root_data
);

    // Heap order with node 1 as the root and node k fed by 2k and 2k+1
    wire [2*tanimoto_pkg::NUM_REFS-1:1]        node_wr;
    wire [2*tanimoto_pkg::NUM_REFS-1:1]        node_rd;
    wire [2*tanimoto_pkg::NUM_REFS-1:1]        node_empty;
    wire [2*tanimoto_pkg::NUM_REFS-1:1]        node_full;
    wire [tanimoto_pkg::NUM_REFS-1:1]          take_left;
    wire [tanimoto_pkg::NUM_REFS-1:0]          leaf_room;
    tanimoto_pkg::id_pair_t                    node_wr_data [1:2*tanimoto_pkg::NUM_REFS-1];
    tanimoto_pkg::id_pair_t                    node_rd_data [1:2*tanimoto_pkg::NUM_REFS-1];
    logic [tanimoto_pkg::FIFO_CNT_WIDTH-1:0]   node_count [1:2*tanimoto_pkg::NUM_REFS-1];

    genvar k;
    generate
        for (k = 1; k < 2*tanimoto_pkg::NUM_REFS; k++) begin : g_node
            sync_fifo u_fifo (
                .clk       (clk),
                .rst       (rst),
                .i_wr      (node_wr[k]),
                .i_wr_data (node_wr_data[k]),
                .i_rd      (node_rd[k]),
                .o_rd_data (node_rd_data[k]),
                .o_empty   (node_empty[k]),
                .o_full    (node_full[k]),
                .o_count   (node_count[k])
            );

            if (k >= tanimoto_pkg::NUM_REFS) begin : g_leaf
                assign node_wr[k] = i_leaf_wr[k-tanimoto_pkg::NUM_REFS];
                assign node_wr_data[k] = i_leaf_data[k-tanimoto_pkg::NUM_REFS];
                assign leaf_room[k-tanimoto_pkg::NUM_REFS] = node_count[k] <
                    tanimoto_pkg::FIFO_CNT_WIDTH'(tanimoto_pkg::FIFO_DEPTH - tanimoto_pkg::FIFO_SLACK);
            end else begin : g_merge
                // Fuller child wins and the left one wins a tie
                assign take_left[k] = node_count[2*k] >= node_count[2*k+1];
                assign node_wr[k] = !node_full[k] &&
                    (take_left[k] ? !node_empty[2*k] : !node_empty[2*k+1]);
                assign node_wr_data[k] = take_left[k] ? node_rd_data[2*k] : node_rd_data[2*k+1];
                assign node_rd[2*k] = node_wr[k] && take_left[k];
                assign node_rd[2*k+1] = node_wr[k] && !take_left[k];
            end
        end
    endgenerate

    assign node_rd[1] = i_root_read;

    // Compare vectors may enter only while all leaves keep their slack
    assign o_room = &leaf_room;
    assign o_root_valid = !node_empty[1];
    assign o_root_data = node_rd_data[1];

endmodule

// ==== logic/tanimoto_top.sv ====
`timescale 1ns/1ps

module tanimoto_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [tanimoto_pkg::VEC_WIDTH-1:0]   i_vec_data,
    input  logic                                 i_vec_valid,
    input  logic                                 i_wb_cyc,
    input  logic                                 i_wb_stb,
    input  logic                                 i_wb_we,
    input  logic [tanimoto_pkg::CNT_WIDTH-1:0]   i_wb_adr,
    input  logic [tanimoto_pkg::SUM_WIDTH-1:0]   i_wb_dat,
    input  logic                                 i_pair_read,
    output logic                                 o_vec_ready,
    output logic                                 o_wb_ack,
    output logic [tanimoto_pkg::SUM_WIDTH-1:0]   o_wb_dat,
    output logic                                 o_pair_valid,
    output tanimoto_pkg::id_pair_t               o_pair_data
);

    logic                                room;
    logic [tanimoto_pkg::VEC_WIDTH-1:0]  ref_vec [tanimoto_pkg::NUM_REFS];
    logic [tanimoto_pkg::CNT_WIDTH-1:0]  ref_cnt [tanimoto_pkg::NUM_REFS];
    logic [tanimoto_pkg::VEC_WIDTH-1:0]  cmp_vec;
    logic [tanimoto_pkg::CNT_WIDTH-1:0]  cmp_cnt;
    logic [tanimoto_pkg::ID_WIDTH-1:0]   cmp_id;
    logic                                cmp_valid;
    logic [tanimoto_pkg::CNT_WIDTH-1:0]  lookup_idx [tanimoto_pkg::NUM_REFS];
    logic [tanimoto_pkg::SUM_WIDTH-1:0]  lookup_val [tanimoto_pkg::NUM_REFS];
    logic [tanimoto_pkg::NUM_REFS-1:0]   leaf_wr;
    tanimoto_pkg::id_pair_t              leaf_data [tanimoto_pkg::NUM_REFS];

    vector_loader u_loader (
        .clk         (clk),
        .rst         (rst),
        .i_vec_data  (i_vec_data),
        .i_vec_valid (i_vec_valid),
        .i_room      (room),
        .o_vec_ready (o_vec_ready),
        .o_ref_vec   (ref_vec),
        .o_ref_cnt   (ref_cnt),
        .o_cmp_vec   (cmp_vec),
        .o_cmp_cnt   (cmp_cnt),
        .o_cmp_id    (cmp_id),
        .o_cmp_valid (cmp_valid)
    );

    threshold_table u_table (
        .clk          (clk),
        .rst          (rst),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_we      (i_wb_we),
        .i_wb_adr     (i_wb_adr),
        .i_wb_dat     (i_wb_dat),
        .i_lookup_idx (lookup_idx),
        .o_wb_ack     (o_wb_ack),
        .o_wb_dat     (o_wb_dat),
        .o_lookup_val (lookup_val)
    );

    // Compare vector goes to every lane at once
    genvar g;
    generate
        for (g = 0; g < tanimoto_pkg::NUM_REFS; g++) begin : g_lane
            similarity_lane #(
                .LANE_ID (g)
            ) u_lane (
                .clk          (clk),
                .rst          (rst),
                .i_ref_vec    (ref_vec[g]),
                .i_ref_cnt    (ref_cnt[g]),
                .i_cmp_vec    (cmp_vec),
                .i_cmp_cnt    (cmp_cnt),
                .i_cmp_id     (cmp_id),
                .i_cmp_valid  (cmp_valid),
                .i_lookup_val (lookup_val[g]),
                .o_lookup_idx (lookup_idx[g]),
                .o_pair_wr    (leaf_wr[g]),
                .o_pair_data  (leaf_data[g])
            );
        end
    endgenerate

    id_fifo_tree u_tree (
        .clk          (clk),
        .rst          (rst),
        .i_leaf_wr    (leaf_wr),
        .i_leaf_data  (leaf_data),
        .i_root_read  (i_pair_read),
        .o_room       (room),
        .o_root_valid (o_pair_valid),
        .o_root_data  (o_pair_data)
    );

endmodule

// ==== testbench/tanimoto_checker.sv ====
`timescale 1ns/1ps

module tanimoto_checker (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 i_vec_valid,
    input  logic                                 i_vec_ready,
    input  logic                                 i_wb_ack,
    input  logic                                 i_wb_we,
    input  logic [tanimoto_pkg::CNT_WIDTH-1:0]   i_wb_adr,
    input  logic [tanimoto_pkg::SUM_WIDTH-1:0]   i_wb_wdat,
    input  logic [tanimoto_pkg::SUM_WIDTH-1:0]   i_wb_rdat,
    input  logic                                 i_pair_read,
    input  logic                                 i_pair_valid,
    input  tanimoto_pkg::id_pair_t               i_pair_data,
    input  logic                                 i_finish,
    output logic                                 o_all_seen,
    output logic                                 o_report_done,
    output int                                   o_value_errors,
    output int                                   o_pair_errors,
    output int                                   o_missing,
    output int                                   o_protocol_errors
);

    bit                                  expected [tanimoto_pkg::NUM_REFS][256];
    bit                                  seen [tanimoto_pkg::NUM_REFS][256];
    logic [tanimoto_pkg::SUM_WIDTH-1:0]  shadow [64] = '{default: '0};
    int                                  expected_total = 0;
    int                                  matched = 0;
    int                                  accepted = 0;
    int                                  value_errors = 0;
    int                                  pair_errors = 0;
    int                                  missing = 0;
    int                                  protocol_errors = 0;
    logic                                rst_q;
    logic                                reported = 1'b0;

    initial begin
        int          fd;
        int          a;
        int          b;
        string       line;
        fd = $fopen("testbench/tanimoto_input.txt", "r");
        if (fd == 0) begin
            $display("Checker cannot open the input file");
            protocol_errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if ($sscanf(line, "E %d %d", a, b) == 2) begin
                    expected[a][b] = 1'b1;
                    expected_total++;
                end
            end
            $fclose(fd);
        end
    end

    task automatic record_pop(input tanimoto_pkg::id_pair_t p);
        logic [tanimoto_pkg::REF_SEL_WIDTH-1:0] r;
        r = p.ref_id[tanimoto_pkg::REF_SEL_WIDTH-1:0];
        if (p.ref_id >= tanimoto_pkg::NUM_REFS || !expected[r][p.cmp_id]) begin
            $display("FAILED pair_set: expected no pair, actual ref %0d cmp %0d",
                     p.ref_id, p.cmp_id);
            pair_errors++;
        end else if (seen[r][p.cmp_id]) begin
            $display("FAILED pair_set: expected ref %0d cmp %0d once, actual a second pop",
                     p.ref_id, p.cmp_id);
            pair_errors++;
        end else begin
            seen[r][p.cmp_id] = 1'b1;
            matched++;
        end
    endtask

    always @(posedge clk) begin
        rst_q <= rst;
        if (rst_q && (i_vec_ready || i_wb_ack || i_pair_valid)) begin
            $display("An output was high during reset or in the cycle after it");
            protocol_errors++;
        end
        if (!rst) begin
            // Pairs cannot exist before the first compare vector
            if (i_pair_valid && accepted <= tanimoto_pkg::NUM_REFS) begin
                $display("Pair output went valid before any compare vector");
                protocol_errors++;
            end
            // References never wait for room in the tree
            if (!rst_q && accepted < tanimoto_pkg::NUM_REFS && !i_vec_ready) begin
                $display("Vector ready was low while references were still loading");
                protocol_errors++;
            end
            if (i_vec_valid && i_vec_ready) begin
                accepted++;
            end
            if (i_wb_ack && i_wb_we && i_wb_adr < tanimoto_pkg::TABLE_DEPTH) begin
                shadow[i_wb_adr] = i_wb_wdat;
            end
            if (i_wb_ack && !i_wb_we && i_wb_rdat !== shadow[i_wb_adr]) begin
                $display("FAILED threshold_round_trip[%0d]: expected %0d actual %0d",
                         i_wb_adr, shadow[i_wb_adr], i_wb_rdat);
                value_errors++;
            end
            if (i_pair_read && !i_pair_valid) begin
                $display("A pop was attempted while the pair output was empty");
                protocol_errors++;
            end
            if (i_pair_read && i_pair_valid) begin
                record_pop(i_pair_data);
            end
            if (i_finish && !reported) begin
                for (int r = 0; r < tanimoto_pkg::NUM_REFS; r++) begin
                    for (int c = 0; c < 256; c++) begin
                        if (expected[r][c] && !seen[r][c]) begin
                            $display("Missing pair: ref %0d cmp %0d never came out", r, c);
                            missing++;
                        end
                    end
                end
                reported = 1'b1;
            end
        end
        o_all_seen <= (matched == expected_total);
        o_report_done <= reported;
        o_value_errors <= value_errors;
        o_pair_errors <= pair_errors;
        o_missing <= missing;
        o_protocol_errors <= protocol_errors;
    end

endmodule

// ==== testbench/tb_tanimoto.sv ====
`timescale 1ns/1ps

module tb_tanimoto;

    logic                                 clk = 1'b0;
    logic                                 rst = 1'b1;
    logic [tanimoto_pkg::VEC_WIDTH-1:0]   i_vec_data = '0;
    logic                                 i_vec_valid = 1'b0;
    logic                                 i_wb_cyc = 1'b0;
    logic                                 i_wb_stb = 1'b0;
    logic                                 i_wb_we = 1'b0;
    logic [tanimoto_pkg::CNT_WIDTH-1:0]   i_wb_adr = '0;
    logic [tanimoto_pkg::SUM_WIDTH-1:0]   i_wb_dat = '0;
    logic                                 i_pair_read = 1'b0;
    logic                                 o_vec_ready;
    logic                                 o_wb_ack;
    logic [tanimoto_pkg::SUM_WIDTH-1:0]   o_wb_dat;
    logic                                 o_pair_valid;
    tanimoto_pkg::id_pair_t               o_pair_data;

    logic                                 finish = 1'b0;
    logic                                 all_seen;
    logic                                 report_done;
    int                                   value_errors;
    int                                   pair_errors;
    int                                   missing;
    int                                   protocol_errors;

    logic [tanimoto_pkg::VEC_WIDTH-1:0]   vec_q [$];
    logic [tanimoto_pkg::CNT_WIDTH-1:0]   thr_adr_q [$];
    logic [tanimoto_pkg::SUM_WIDTH-1:0]   thr_val_q [$];
    int                                   num_records = 0;
    logic [31:0]                          rnd_state = 32'hd820_8d58;

    always #5 clk = ~clk;

    tanimoto_top tanimoto_top_i (.*);

    tanimoto_checker tanimoto_checker_i (
        .clk               (clk),
        .rst               (rst),
        .i_vec_valid       (i_vec_valid),
        .i_vec_ready       (o_vec_ready),
        .i_wb_ack          (o_wb_ack),
        .i_wb_we           (i_wb_we),
        .i_wb_adr          (i_wb_adr),
        .i_wb_wdat         (i_wb_dat),
        .i_wb_rdat         (o_wb_dat),
        .i_pair_read       (i_pair_read),
        .i_pair_valid      (o_pair_valid),
        .i_pair_data       (o_pair_data),
        .i_finish          (finish),
        .o_all_seen        (all_seen),
        .o_report_done     (report_done),
        .o_value_errors    (value_errors),
        .o_pair_errors     (pair_errors),
        .o_missing         (missing),
        .o_protocol_errors (protocol_errors)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic read_input();
        int          fd;
        int          a;
        int          b;
        logic [31:0] v;
        string       line;
        fd = $fopen("testbench/tanimoto_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open testbench/tanimoto_input.txt");
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "T %d %d", a, b) == 2) begin
                thr_adr_q.push_back(tanimoto_pkg::CNT_WIDTH'(a));
                thr_val_q.push_back(tanimoto_pkg::SUM_WIDTH'(b));
                num_records++;
            end else if ($sscanf(line, "V %h", v) == 1) begin
                vec_q.push_back(v);
                num_records++;
            end else if ($sscanf(line, "E %d %d", a, b) == 2) begin
                num_records++;
            end
        end
        $fclose(fd);
    endtask

    // One classic cycle held until the ack comes back
    task automatic wb_access(input logic we, input logic [tanimoto_pkg::CNT_WIDTH-1:0] adr,
                             input logic [tanimoto_pkg::SUM_WIDTH-1:0] dat);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we <= we;
        i_wb_adr <= adr;
        i_wb_dat <= dat;
        @(posedge clk);
        while (!o_wb_ack) @(posedge clk);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        i_wb_we <= 1'b0;
        @(posedge clk);
    endtask

    task automatic send_vector(input logic [tanimoto_pkg::VEC_WIDTH-1:0] v);
        i_vec_data <= v;
        i_vec_valid <= 1'b1;
        @(posedge clk);
        while (!o_vec_ready) @(posedge clk);
    endtask

    // Random single-cycle pops that never come two in a row
    always @(posedge clk) begin
        rnd_state <= xorshift(rnd_state);
        if (rst) begin
            i_pair_read <= 1'b0;
        end else begin
            i_pair_read <= !i_pair_read && o_pair_valid && rnd_state[0];
        end
    end

    initial begin
        int idle;
        read_input();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        foreach (thr_adr_q[i]) begin
            wb_access(1'b1, thr_adr_q[i], thr_val_q[i]);
            wb_access(1'b0, thr_adr_q[i], '0);
        end
        foreach (vec_q[i]) begin
            send_vector(vec_q[i]);
        end
        i_vec_valid <= 1'b0;
        while (!all_seen) @(posedge clk);
        // Give stray pairs a chance to surface
        idle = 0;
        while (idle < 8) begin
            @(posedge clk);
            idle = o_pair_valid ? 0 : idle + 1;
        end
        finish <= 1'b1;
        @(posedge clk);
        while (!report_done) @(posedge clk);
        $display("Error counts: value %0d, pair %0d, missing %0d, protocol %0d",
                 value_errors, pair_errors, missing, protocol_errors);
        if (value_errors + pair_errors + missing + protocol_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        wait (num_records > 0);
        repeat (200 * num_records + 100) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", 200 * num_records + 100);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== testbench/tanimoto_input.txt ====
# T <table index c> <largest allowed a+b>   V <hex vector>, first four are references
# E <reference id> <compare id> for each pair that must come out
T 0 0
T 8 24
T 16 32
V 000000FF
V 0000FF00
V 00FF0000
V 0F0F0F0F
V 000000FF
V 0F0F0F0F
V F0000000
V 0000FFFF
V 000F000F
V FFFFFFFF
V 00FF00FF
V 00FFFF00
V 0000000F
E 0 4
E 3 5
E 0 7
E 1 7
E 3 8
E 0 10
E 2 10
E 1 11
E 2 11

// ==== sim.f ====
logic/tanimoto_pkg.sv
logic/vector_loader.sv
logic/threshold_table.sv
logic/similarity_lane.sv
logic/sync_fifo.sv
logic/id_fifo_tree.sv
logic/tanimoto_top.sv
testbench/tanimoto_checker.sv
testbench/tb_tanimoto.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the Tanimoto screener simulation with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal -f sim.f --top-module tb_tanimoto -o tb_tanimoto
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_tanimoto > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
